//--- design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_WIDTH 16
`define CPU_REG_COUNT 16
`define CPU_REG_ADDR_WIDTH 4
`define CPU_RESET_PC 16'h0000

// Instruction fields
`define CPU_FIELD_WIDTH 4
`define CPU_IMM_WIDTH 8
`define CPU_UPPER_SHIFT 8

`endif

//--- design/cpuIsaPkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpuIsaPkg;

    typedef enum logic [`CPU_FIELD_WIDTH-1:0] {
        majorAlu        = 4'd0,
        majorAddImm     = 4'd1,
        majorLoadUpper  = 4'd2,
        majorBranchZero = 4'd3,
        majorJumpLink   = 4'd4
    } majorOp;

    // Minor values 8 to 15 behave as pass-B
    typedef enum logic [`CPU_FIELD_WIDTH-1:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluShl   = 4'd5,
        aluShr   = 4'd6,
        aluPassB = 4'd7
    } aluOp;

    typedef union packed {
        struct packed {
            majorOp                       major;
            logic [`CPU_FIELD_WIDTH-1:0]  regA;
            logic [`CPU_FIELD_WIDTH-1:0]  regB;
            aluOp                         minor;
        } regForm;
        struct packed {
            majorOp                       major;
            logic [`CPU_FIELD_WIDTH-1:0]  regA;
            logic [`CPU_IMM_WIDTH-1:0]    imm8;
        } immForm;
    } instrWord;

endpackage

`default_nettype wire

//--- design/cpuPipePkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpuPipePkg;

    typedef struct packed {
        logic                          valid;
        logic [`CPU_DATA_WIDTH-1:0]    pc;
        logic [`CPU_DATA_WIDTH-1:0]    instr;
    } fetchBundle;

    typedef struct packed {
        logic                          valid;
        cpuIsaPkg::aluOp               aluOp;
        logic                          isBranch;
        logic                          isLink;
        logic                          writeEn;
        logic [`CPU_REG_ADDR_WIDTH-1:0] writeAddr;
        logic [`CPU_DATA_WIDTH-1:0]    pc;
        logic [`CPU_DATA_WIDTH-1:0]    operandA;
        logic [`CPU_DATA_WIDTH-1:0]    operandB;
        logic [`CPU_DATA_WIDTH-1:0]    branchOffset;
    } issueBundle;

    typedef struct packed {
        logic                          en;
        logic [`CPU_REG_ADDR_WIDTH-1:0] addr;
        logic [`CPU_DATA_WIDTH-1:0]    data;
    } regWrite;

    typedef struct packed {
        logic                          valid;
        logic [`CPU_DATA_WIDTH-1:0]    target;
    } redirect;

    // Read-only Wishbone classic bus
    typedef struct packed {
        logic                          cyc;
        logic                          stb;
        logic [`CPU_DATA_WIDTH-1:0]    adr;
    } wbReq;

    typedef struct packed {
        logic                          ack;
        logic [`CPU_DATA_WIDTH-1:0]    dat;
    } wbRsp;

endpackage

`default_nettype wire

//--- design/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module fetchUnit (
    input  wire                         clk,
    input  wire                         arstN,
    output cpuPipePkg::wbReq            bus,
    input  wire cpuPipePkg::wbRsp       busRsp,
    input  wire                         fetchHold,
    input  wire cpuPipePkg::redirect    redirect,
    output cpuPipePkg::fetchBundle      fetched
);
    typedef enum logic [1:0] {
        stIdle,
        stBus,
        stDeliver
    } fetchState;

    fetchState state;
    logic [`CPU_DATA_WIDTH-1:0] pc;
    logic [`CPU_DATA_WIDTH-1:0] fetchAddr;
    logic [`CPU_DATA_WIDTH-1:0] busAdr;
    logic [`CPU_DATA_WIDTH-1:0] fetchPc;
    logic [`CPU_DATA_WIDTH-1:0] fetchInstr;
    logic startFetch;
    logic busDone;

    // A pending redirect replaces the PC for this fetch
    assign fetchAddr = redirect.valid ? redirect.target : pc;
    // Bus is free again while the last word is delivered
    assign startFetch = (state == stIdle || state == stDeliver) && !fetchHold;
    assign busDone = (state == stBus) && busRsp.ack;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (startFetch) begin
                        state <= stBus;
                    end
                end
                stBus: begin
                    if (busRsp.ack) begin
                        state <= stDeliver;
                    end
                end
                stDeliver: begin
                    state <= startFetch ? stBus : stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `CPU_RESET_PC;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (busDone) begin
            pc <= pc + 1'b1;
        end
    end

    // Address held stable for the whole bus cycle
    always_ff @(posedge clk) begin
        if (startFetch) begin
            busAdr <= fetchAddr;
        end
        if (busDone) begin
            fetchPc <= busAdr;
            fetchInstr <= busRsp.dat;
        end
    end

    assign bus = '{cyc: state == stBus, stb: state == stBus, adr: busAdr};
    assign fetched = '{valid: state == stDeliver, pc: fetchPc, instr: fetchInstr};

endmodule

`default_nettype wire

//--- design/registerFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module registerFile (
    input  wire                             clk,
    input  wire                             arstN,
    input  wire [`CPU_REG_ADDR_WIDTH-1:0]   readAddrA,
    input  wire [`CPU_REG_ADDR_WIDTH-1:0]   readAddrB,
    output logic [`CPU_DATA_WIDTH-1:0]      readDataA,
    output logic [`CPU_DATA_WIDTH-1:0]      readDataB,
    input  wire cpuPipePkg::regWrite        writePort
);
    logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (writePort.en) begin
            regs[writePort.addr] <= writePort.data;
        end
    end

    // Reads see the old value during a write
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- design/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module decodeStage (
    input  wire                         clk,
    input  wire                         arstN,
    input  wire cpuPipePkg::fetchBundle fetched,
    input  wire cpuPipePkg::regWrite    result,
    output logic                        fetchHold,
    output cpuPipePkg::issueBundle      issued
);
    cpuIsaPkg::instrWord instr;
    cpuIsaPkg::aluOp minorOp;
    cpuPipePkg::issueBundle issueNext;
    logic [`CPU_DATA_WIDTH-1:0] regDataA;
    logic [`CPU_DATA_WIDTH-1:0] regDataB;
    logic [`CPU_DATA_WIDTH-1:0] operandA;
    logic [`CPU_DATA_WIDTH-1:0] regB;
    logic [`CPU_DATA_WIDTH-1:0] signImm;
    logic [`CPU_DATA_WIDTH-1:0] upperImm;

    assign instr = fetched.instr;

    registerFile regFileInst (
        .clk       (clk),
        .arstN     (arstN),
        .readAddrA (instr.regForm.regA),
        .readAddrB (instr.regForm.regB),
        .readDataA (regDataA),
        .readDataB (regDataB),
        .writePort (result)
    );

    // Bypass the result being written this cycle
    assign operandA = (result.en && result.addr == instr.regForm.regA) ? result.data : regDataA;
    assign regB = (result.en && result.addr == instr.regForm.regB) ? result.data : regDataB;

    assign signImm = {{(`CPU_DATA_WIDTH-`CPU_IMM_WIDTH){instr.immForm.imm8[`CPU_IMM_WIDTH-1]}},
                      instr.immForm.imm8};
    assign upperImm = {{(`CPU_DATA_WIDTH-`CPU_IMM_WIDTH){1'b0}}, instr.immForm.imm8}
                      << `CPU_UPPER_SHIFT;

    // Upper minor codes fold into pass-B
    assign minorOp = instr.regForm.minor[3] ? cpuIsaPkg::aluPassB : instr.regForm.minor;

    always_comb begin
        issueNext = '0;
        issueNext.valid = fetched.valid;
        issueNext.aluOp = cpuIsaPkg::aluPassB;
        issueNext.writeAddr = instr.regForm.regA;
        issueNext.pc = fetched.pc;
        issueNext.operandA = operandA;
        issueNext.operandB = regB;
        issueNext.branchOffset = signImm;
        case (instr.regForm.major)
            cpuIsaPkg::majorAlu: begin
                issueNext.aluOp = minorOp;
                issueNext.writeEn = 1'b1;
            end
            cpuIsaPkg::majorAddImm: begin
                issueNext.aluOp = cpuIsaPkg::aluAdd;
                issueNext.operandB = signImm;
                issueNext.writeEn = 1'b1;
            end
            cpuIsaPkg::majorLoadUpper: begin
                issueNext.operandB = upperImm;
                issueNext.writeEn = 1'b1;
            end
            cpuIsaPkg::majorBranchZero: issueNext.isBranch = 1'b1;
            cpuIsaPkg::majorJumpLink: begin
                issueNext.isLink = 1'b1;
                issueNext.writeEn = 1'b1;
            end
            default: issueNext.writeEn = 1'b0;
        endcase
    end

    // No fetch until control flow is resolved in execute
    assign fetchHold = (fetched.valid && (issueNext.isBranch || issueNext.isLink))
                    || (issued.valid && (issued.isBranch || issued.isLink));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issued <= '0;
        end else begin
            issued <= issueNext;
        end
    end

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module executeStage (
    input  wire                         clk,
    input  wire                         arstN,
    input  wire cpuPipePkg::issueBundle issued,
    output cpuPipePkg::regWrite         result,
    output cpuPipePkg::redirect         redirect
);
    logic [`CPU_DATA_WIDTH-1:0] aluResult;
    logic [`CPU_DATA_WIDTH-1:0] linkValue;
    logic [`CPU_DATA_WIDTH-1:0] target;
    logic branchTaken;

    always_comb begin
        case (issued.aluOp)
            cpuIsaPkg::aluAdd: aluResult = issued.operandA + issued.operandB;
            cpuIsaPkg::aluSub: aluResult = issued.operandA - issued.operandB;
            cpuIsaPkg::aluAnd: aluResult = issued.operandA & issued.operandB;
            cpuIsaPkg::aluOr:  aluResult = issued.operandA | issued.operandB;
            cpuIsaPkg::aluXor: aluResult = issued.operandA ^ issued.operandB;
            cpuIsaPkg::aluShl: aluResult = issued.operandA << 1;
            cpuIsaPkg::aluShr: aluResult = issued.operandA >> 1;
            default:           aluResult = issued.operandB;
        endcase
    end

    assign linkValue = issued.pc + 1'b1;
    assign branchTaken = issued.isBranch && (issued.operandA == '0);

    // Link jumps to register B, branches are PC relative
    assign target = issued.isLink ? issued.operandB : issued.pc + issued.branchOffset;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
            redirect <= '0;
        end else begin
            result.en <= issued.valid && issued.writeEn;
            result.addr <= issued.writeAddr;
            result.data <= issued.isLink ? linkValue : aluResult;
            redirect.valid <= issued.valid && (branchTaken || issued.isLink);
            redirect.target <= target;
        end
    end

endmodule

`default_nettype wire

//--- design/cpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  wire                         clk,
    input  wire                         arstN,
    output cpuPipePkg::wbReq            bus,
    input  wire cpuPipePkg::wbRsp       busRsp,
    output cpuPipePkg::regWrite         regWriteOut
);
    cpuPipePkg::fetchBundle fetched;
    cpuPipePkg::issueBundle issued;
    cpuPipePkg::regWrite result;
    cpuPipePkg::redirect redirect;
    logic fetchHold;

    fetchUnit fetchInst (
        .clk       (clk),
        .arstN     (arstN),
        .bus       (bus),
        .busRsp    (busRsp),
        .fetchHold (fetchHold),
        .redirect  (redirect),
        .fetched   (fetched)
    );

    decodeStage decodeInst (
        .clk       (clk),
        .arstN     (arstN),
        .fetched   (fetched),
        .result    (result),
        .fetchHold (fetchHold),
        .issued    (issued)
    );

    executeStage executeInst (
        .clk       (clk),
        .arstN     (arstN),
        .issued    (issued),
        .result    (result),
        .redirect  (redirect)
    );

    assign regWriteOut = result;

endmodule

`default_nettype wire

//--- tests/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter real periodNs = 4.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(periodNs / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tests/cpuTop_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpuTop_assert (
    input wire                          clk,
    input wire                          arstN,
    input wire cpuPipePkg::wbReq        bus,
    input wire cpuPipePkg::wbRsp        busRsp,
    input wire cpuPipePkg::regWrite     regWriteOut
);
    int unsigned violations = 0;

    stbNeedsCyc: assert property (@(posedge clk) disable iff (!arstN)
        bus.stb |-> bus.cyc)
    else begin
        violations++;
        $error("Wishbone stb high without cyc");
    end

    // Classic cycle holds its address until ack
    adrHeld: assert property (@(posedge clk) disable iff (!arstN)
        (bus.stb && !busRsp.ack) |=> (bus.stb && $stable(bus.adr)))
    else begin
        violations++;
        $error("Wishbone adr or stb changed before ack");
    end

    quietInReset: assert property (@(posedge clk)
        !arstN |-> !regWriteOut.en)
    else begin
        violations++;
        $error("register write during reset");
    end

endmodule

bind cpuTop cpuTop_assert busRules (.*);

`default_nettype wire

//--- tests/cpuTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_settings.svh"

module cpuTb;
    localparam int memWords = 256;
    localparam int dataWords = 512;
    localparam int waitLimit = 200;
    localparam int quietCycles = 40;
    localparam int resetCycles = 16;

    logic clk;
    logic arstN = 1'b0;
    cpuPipePkg::wbReq busReq;
    cpuPipePkg::wbRsp busRsp = '0;
    cpuPipePkg::regWrite regWriteOut;

    logic [`CPU_DATA_WIDTH-1:0] progMem [memWords];
    logic [`CPU_DATA_WIDTH-1:0] testData [dataWords];
    integer seed = 32'hf039;
    logic readPending = 1'b0;
    int waitLeft = 0;
    int dataPtr = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;

    clockGen clockInst (
        .clk (clk)
    );

    cpuTop cpuTop_inst (
        .clk         (clk),
        .arstN       (arstN),
        .bus         (busReq),
        .busRsp      (busRsp),
        .regWriteOut (regWriteOut)
    );

    // Wishbone slave with 0 to 3 wait states per read
    always @(negedge clk) begin
        if (!arstN || busRsp.ack || !(busReq.cyc && busReq.stb)) begin
            busRsp <= '0;
            readPending = 1'b0;
        end else begin
            if (!readPending) begin
                readPending = 1'b1;
                waitLeft = {$random(seed)} % 4;
            end
            if (waitLeft == 0) begin
                busRsp <= '{ack: 1'b1, dat: progMem[busReq.adr[7:0]]};
            end else begin
                waitLeft--;
            end
        end
    end

    task automatic checkValue(input string name, input logic [`CPU_DATA_WIDTH-1:0] actual,
                              input logic [`CPU_DATA_WIDTH-1:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic resetAndLoad(input int progLen);
        int addr;
        @(negedge clk);
        arstN = 1'b0;
        // Filler words are no-ops tagged with their address
        for (addr = 0; addr < memWords; addr++) begin
            progMem[addr] = 16'hF000 | 16'(addr);
        end
        for (addr = 0; addr < progLen; addr++) begin
            progMem[addr] = testData[dataPtr + addr];
        end
        dataPtr += progLen;
        repeat (resetCycles) @(negedge clk);
        checkValue("bus.cyc", 16'(busReq.cyc), 16'h0);
        checkValue("bus.stb", 16'(busReq.stb), 16'h0);
        checkValue("regWriteOut.en", 16'(regWriteOut.en), 16'h0);
        arstN = 1'b1;
    endtask

    task automatic waitFirstAck(input int testId);
        int cycles;
        cycles = 0;
        // No write can appear before the first word is fetched
        while (!busRsp.ack && cycles < waitLimit) begin
            @(negedge clk);
            checkValue("regWriteOut.en", 16'(regWriteOut.en), 16'h0);
            cycles++;
        end
        if (!busRsp.ack) begin
            errorCount++;
            $display("timeout: no bus acknowledge in test %0d", testId);
        end
    endtask

    task automatic collectWrites(input int testId, input int writeCount);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < writeCount && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
            if (regWriteOut.en) begin
                checkValue("regWriteOut.addr", 16'(regWriteOut.addr), testData[dataPtr]);
                checkValue("regWriteOut.data", regWriteOut.data, testData[dataPtr + 1]);
                dataPtr += 2;
                seen++;
                cycles = 0;
            end
        end
        if (seen < writeCount) begin
            errorCount++;
            $display("timeout: test %0d saw %0d of %0d register writes",
                     testId, seen, writeCount);
            dataPtr += 2 * (writeCount - seen);
        end
        // Trace must end after the last expected write
        cycles = 0;
        while (cycles < quietCycles) begin
            @(negedge clk);
            cycles++;
            if (regWriteOut.en) begin
                errorCount++;
                $display("extra write to register %0d in test %0d", regWriteOut.addr, testId);
            end
        end
    endtask

    initial begin
        int testId;
        int progLen;
        int writeCount;
        int firstErrors;
        $readmemh("tests/cpu_testdata.hex", testData);
        if ($isunknown(testData[0])) begin
            errorCount++;
            $display("no test data could be read");
        end
        while (!$isunknown(testData[dataPtr]) && testData[dataPtr] != '0
               && dataPtr < dataWords - 3) begin
            testId = testData[dataPtr];
            progLen = testData[dataPtr + 1];
            writeCount = testData[dataPtr + 2];
            dataPtr += 3;
            firstErrors = errorCount;
            resetAndLoad(progLen);
            waitFirstAck(testId);
            collectWrites(testId, writeCount);
            testCount++;
            if (errorCount == firstErrors) begin
                $display("test %0d: %0d writes matched", testId, writeCount);
            end else begin
                $display("test %0d: %0d errors", testId, errorCount - firstErrors);
            end
        end
        $display("tests run: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
                 testCount, checkCount, errorCount, cpuTop_inst.busRules.violations);
        if (errorCount == 0 && cpuTop_inst.busRules.violations == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/cpuIsaPkg.sv
design/cpuPipePkg.sv
design/fetchUnit.sv
design/registerFile.sv
design/decodeStage.sv
design/executeStage.sv
design/cpuTop.sv
tests/clockGen.sv
tests/cpuTop_assert.sv
tests/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= test passed
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/cpu_testdata.hex
// Header per test: test id, program length, expected write count
// Then program words from address 0, then register/value write pairs; id 0 ends
// Register form ALU, all minor opcodes plus a folded one
0001 000E 000E
1125 2212 1207 0327 0310 0321 0322 0323
0314 0305 0306 041C 2580 0506
0001 0025  0002 1200  0002 1207  0003 1207
0003 122C  0003 0025  0003 0005  0003 1207
0003 1222  0003 2444  0003 1222  0004 0025
0005 8000  0005 4000
// Add immediate both signs, load upper
0002 0008 0008
1105 11FD 11F0 127F 23AB 1380 2400 1F01
0001 0005  0001 0002  0001 FFF2  0002 007F
0003 AB00  0003 AA80  0004 0000  000F 0001
// Dependent chain, each op reads the previous result
0003 000A 000A
1101 0210 0120 0210 0120 0210 0120 0210 0327 0305
0001 0001  0002 0001  0001 0002  0002 0003
0001 0005  0002 0008  0001 000D  0002 0015
0003 0015  0003 002A
// Branch if zero, skip forward and count down in a loop
0004 000A 0006
1103 3102 1201 3003 1277 1377 11FF 3102 30FE 1242
0001 0003  0002 0001  0001 0002  0001 0001
0001 0000  0002 0043
// Call through r2, return through r3, then spin on a branch to self
0005 0008 0005
1206 4320 1555 3000 1477 1477 1421 4130
0002 0006  0003 0002  0004 0021  0001 0008  0005 0055
0000
